//--- combine_csr.sv
/*
 * Combiner control registers on a Wishbone classic slave: shift and
 * lane mask, plus output sample and frame counters.
 */
`timescale 1ns/1ns

module combine_csr (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic [1:0]  shift,
    output logic [3:0]  lane_mask,
    input  logic        out_valid,
    input  logic        out_ready,
    input  logic        out_last
);

    logic [31:0] frame_cnt;
    logic [31:0] sample_cnt;
    logic        req;
    logic        wr;
    logic        xfer;

    // one cycle ack, next request only after ack has dropped
    assign req  = wb_cyc && wb_stb && !wb_ack;
    assign wr   = req && wb_we;
    assign xfer = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // --------------------------------------------------
    // control register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            shift     <= '0;
            lane_mask <= '0;
        end else if (wr && wb_adr == iq_combine_pkg::reg_ctrl) begin
            shift     <= wb_dat_w[1:0];
            lane_mask <= wb_dat_w[7:4];
        end
    end

    // --------------------------------------------------
    // counters, a write to either address clears it
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            sample_cnt <= '0;
            frame_cnt  <= '0;
        end else begin
            if (wr && wb_adr == iq_combine_pkg::reg_samples) begin
                sample_cnt <= '0;
            end else if (xfer) begin
                sample_cnt <= sample_cnt + 1'b1;
            end
            if (wr && wb_adr == iq_combine_pkg::reg_frames) begin
                frame_cnt <= '0;
            end else if (xfer && out_last) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    // read data, held alongside ack
    always_ff @(posedge clk) begin
        if (req) begin
            case (wb_adr)
                iq_combine_pkg::reg_ctrl:    wb_dat_r <= {24'd0, lane_mask, 2'd0, shift};
                iq_combine_pkg::reg_frames:  wb_dat_r <= frame_cnt;
                iq_combine_pkg::reg_samples: wb_dat_r <= sample_cnt;
                default:                     wb_dat_r <= '0;
            endcase
        end
    end

endmodule

//--- iq_combine_pkg.sv
/*
 * IQ combiner shared definitions: lane count, sample layout, shift codes
 * and control register word addresses.
 */
package iq_combine_pkg;

    // adder tree is built for exactly four lanes
    localparam int num_lanes = 4;

    localparam int part_width   = 16;
    localparam int sample_width = 2 * part_width;

    // real part in the upper half, imaginary part in the lower half
    typedef struct packed {
        logic [part_width-1:0] re;
        logic [part_width-1:0] im;
    } sample_t;

    // two adder levels add two bits of growth
    localparam int sum_width = part_width + 2;

    // output scaling, code 3 falls back to no shift
    localparam logic [1:0] shift_none    = 2'd0;
    localparam logic [1:0] shift_half    = 2'd1;
    localparam logic [1:0] shift_quarter = 2'd2;

    // wishbone word addresses
    localparam logic [1:0] reg_ctrl    = 2'd0;
    localparam logic [1:0] reg_frames  = 2'd1;
    localparam logic [1:0] reg_samples = 2'd2;

    localparam int fifo_depth_default = 8;

endpackage

//--- iq_combiner_top.sv
/*
 * Four-lane IQ combiner: lane FIFOs feeding a pipelined sum tree,
 * with a Wishbone register block for scaling, masking and counters.
 */
`timescale 1ns/1ns

module iq_combiner_top #(
    parameter int FIFO_DEPTH = iq_combine_pkg::fifo_depth_default
) (
    input  logic                                                      clk,
    input  logic                                                      reset,
    input  logic [iq_combine_pkg::num_lanes*iq_combine_pkg::sample_width-1:0] lane_data,
    input  logic [iq_combine_pkg::num_lanes-1:0]                      lane_valid,
    input  logic [iq_combine_pkg::num_lanes-1:0]                      lane_last,
    output logic [iq_combine_pkg::num_lanes-1:0]                      lane_ready,
    output logic [iq_combine_pkg::sample_width-1:0]                   out_data,
    output logic                                                      out_valid,
    output logic                                                      out_last,
    input  logic                                                      out_ready,
    input  logic                                                      wb_cyc,
    input  logic                                                      wb_stb,
    input  logic                                                      wb_we,
    input  logic [1:0]                                                wb_adr,
    input  logic [31:0]                                               wb_dat_w,
    output logic [31:0]                                               wb_dat_r,
    output logic                                                      wb_ack
);

    localparam int sw = iq_combine_pkg::sample_width;

    logic [iq_combine_pkg::num_lanes*sw-1:0]   fifo_data;
    logic [iq_combine_pkg::num_lanes-1:0]      fifo_valid;
    logic [iq_combine_pkg::num_lanes-1:0]      fifo_last;
    logic                                      tree_take;
    logic [1:0]                                shift;
    logic [3:0]                                lane_mask;

    for (genvar i = 0; i < iq_combine_pkg::num_lanes; i++) begin : g_lane
        lane_fifo #(
            .FIFO_DEPTH(FIFO_DEPTH)
        ) u_fifo (
            .clk      (clk),
            .reset    (reset),
            .mask     (lane_mask[i]),
            .in_data  (lane_data[i*sw +: sw]),
            .in_valid (lane_valid[i]),
            .in_last  (lane_last[i]),
            .in_ready (lane_ready[i]),
            .out_data (fifo_data[i*sw +: sw]),
            .out_valid(fifo_valid[i]),
            .out_last (fifo_last[i]),
            .take     (tree_take)
        );
    end

    iq_sum_tree u_tree (
        .clk       (clk),
        .reset     (reset),
        .shift     (shift),
        .lane_data (fifo_data),
        .lane_valid(fifo_valid),
        .lane_last (fifo_last),
        .take      (tree_take),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    combine_csr u_csr (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .shift    (shift),
        .lane_mask(lane_mask),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_last (out_last)
    );

endmodule

//--- iq_sum_tree.sv
/*
 * Pipelined complex adder tree for four lanes with a selectable
 * right shift at the last stage.
 */
`timescale 1ns/1ns

module iq_sum_tree (
    input  logic                                                      clk,
    input  logic                                                      reset,
    input  logic [1:0]                                                shift,
    input  logic [iq_combine_pkg::num_lanes*iq_combine_pkg::sample_width-1:0] lane_data,
    input  logic [iq_combine_pkg::num_lanes-1:0]                      lane_valid,
    input  logic [iq_combine_pkg::num_lanes-1:0]                      lane_last,
    output logic                                                      take,
    output logic [iq_combine_pkg::sample_width-1:0]                   out_data,
    output logic                                                      out_valid,
    output logic                                                      out_last,
    input  logic                                                      out_ready
);

    localparam int pw = iq_combine_pkg::part_width;
    localparam int sw = iq_combine_pkg::sample_width;
    localparam int tw = iq_combine_pkg::sum_width;

    logic advance;

    // stage 0
    iq_combine_pkg::sample_t s0_lane [iq_combine_pkg::num_lanes];
    logic                    s0_valid;
    logic                    s0_last;

    // stage 1
    logic signed [pw:0] s1_re01;
    logic signed [pw:0] s1_re23;
    logic signed [pw:0] s1_im01;
    logic signed [pw:0] s1_im23;
    logic               s1_valid;
    logic               s1_last;

    // stage 2
    logic signed [tw-1:0] s2_re;
    logic signed [tw-1:0] s2_im;
    logic                 s2_valid;
    logic                 s2_last;

    // whole pipeline moves together, stalls only when output is held
    assign advance = !out_valid || out_ready;
    assign take    = advance && (&lane_valid);

    // --------------------------------------------------
    // valid chain
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            s0_valid  <= 1'b0;
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s0_valid  <= take;
            s1_valid  <= s0_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    // --------------------------------------------------
    // data path
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < iq_combine_pkg::num_lanes; i++) begin
                s0_lane[i] <= iq_combine_pkg::sample_t'(lane_data[i*sw +: sw]);
            end
            // frame ends only when every lane ends together
            s0_last <= &lane_last;

            s1_re01 <= $signed(s0_lane[0].re) + $signed(s0_lane[1].re);
            s1_re23 <= $signed(s0_lane[2].re) + $signed(s0_lane[3].re);
            s1_im01 <= $signed(s0_lane[0].im) + $signed(s0_lane[1].im);
            s1_im23 <= $signed(s0_lane[2].im) + $signed(s0_lane[3].im);
            s1_last <= s0_last;

            s2_re   <= s1_re01 + s1_re23;
            s2_im   <= s1_im01 + s1_im23;
            s2_last <= s1_last;

            // no saturation, selected bits simply wrap
            case (shift)
                iq_combine_pkg::shift_half: begin
                    out_data <= {s2_re[pw:1], s2_im[pw:1]};
                end
                iq_combine_pkg::shift_quarter: begin
                    out_data <= {s2_re[pw+1:2], s2_im[pw+1:2]};
                end
                default: begin
                    out_data <= {s2_re[pw-1:0], s2_im[pw-1:0]};
                end
            endcase
            out_last <= s2_last;
        end
    end

endmodule

//--- lane_fifo.sv
/*
 * Lane FIFO: circular buffer of samples with end-of-frame flags.
 * A masked lane drains, swallows its input and offers a zero last sample.
 */
`timescale 1ns/1ns

module lane_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   mask,
    input  logic [iq_combine_pkg::sample_width-1:0] in_data,
    input  logic                                   in_valid,
    input  logic                                   in_last,
    output logic                                   in_ready,
    output logic [iq_combine_pkg::sample_width-1:0] out_data,
    output logic                                   out_valid,
    output logic                                   out_last,
    input  logic                                   take
);

    localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

    logic [iq_combine_pkg::sample_width-1:0] mem_data [FIFO_DEPTH];
    logic                                   mem_last [FIFO_DEPTH];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == cnt_w'(FIFO_DEPTH));
    assign push = in_valid && !full && !mask;
    assign pop  = take && (count != '0) && !mask;

    assign in_ready  = mask || !full;
    assign out_valid = mask || (count != '0);
    assign out_data  = mask ? '0 : mem_data[rd_ptr];
    assign out_last  = mask || mem_last[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr] <= in_data;
            mem_last[wr_ptr] <= in_last;
        end
    end

    // pointers and fill level
    always_ff @(posedge clk) begin
        if (reset || mask) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the IQ combiner testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --timescale 1ns/1ns --top-module tb_iq_combiner \
    -f sources.f -o sim_tb \
    || { echo "compile failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -qx "Done: no errors" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sources.f
+incdir+.
iq_combine_pkg.sv
lane_fifo.sv
iq_sum_tree.sv
combine_csr.sv
iq_combiner_top.sv
tb_iq_combiner.sv

//--- tb_iq_checks.svh
/*
 * IQ combiner testbench helpers: random source, reference combine
 * and compare tasks for output samples, last flags and register words.
 */
`ifndef TB_IQ_CHECKS_SVH
`define TB_IQ_CHECKS_SVH

logic [31:0] lcg_state = 32'hd25e79a5;

int sample_errors = 0;
int last_errors   = 0;
int word_errors   = 0;
int other_errors  = 0;
int stray_outputs = 0;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// upper bits of the generator, low bits repeat too quickly
function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:16]) % n;
endfunction

// --------------------------------------------------
// expected output of one set of lanes
// --------------------------------------------------
function automatic iq_combine_pkg::sample_t ref_combine(
    input logic [iq_combine_pkg::num_lanes*iq_combine_pkg::sample_width-1:0] lanes,
    input logic [iq_combine_pkg::num_lanes-1:0]                             mask,
    input logic [1:0]                                                       shift
);
    logic signed [31:0]      re_sum;
    logic signed [31:0]      im_sum;
    iq_combine_pkg::sample_t s;
    iq_combine_pkg::sample_t res;
    re_sum = 0;
    im_sum = 0;
    for (int l = 0; l < iq_combine_pkg::num_lanes; l++) begin
        s = lanes[l*iq_combine_pkg::sample_width +: iq_combine_pkg::sample_width];
        if (!mask[l]) begin
            re_sum = re_sum + 32'($signed(s.re));
            im_sum = im_sum + 32'($signed(s.im));
        end
    end
    // code 3 falls through to the unscaled case
    if (shift == iq_combine_pkg::shift_half) begin
        re_sum = re_sum >>> 1;
        im_sum = im_sum >>> 1;
    end else if (shift == iq_combine_pkg::shift_quarter) begin
        re_sum = re_sum >>> 2;
        im_sum = im_sum >>> 2;
    end
    res.re = re_sum[15:0];
    res.im = im_sum[15:0];
    return res;
endfunction

task automatic check_sample(input iq_combine_pkg::sample_t got,
                            input iq_combine_pkg::sample_t exp, input string name);
    if (got !== exp) begin
        sample_errors++;
        $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_last(input logic got, input logic exp, input string name);
    if (got !== exp) begin
        last_errors++;
        $display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string name);
    if (got !== exp) begin
        word_errors++;
        $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
endtask

`endif

//--- tb_iq_combiner.sv
/*
 * IQ combiner testbench: skewed random lane traffic, Wishbone register
 * access, and a checker that compares every output against the reference.
 */
`timescale 1ns/1ns

module tb_iq_combiner;

    localparam int nl = iq_combine_pkg::num_lanes;
    localparam int sw = iq_combine_pkg::sample_width;

    logic             clk;
    logic             reset;
    logic [nl*sw-1:0] lane_data;
    logic [nl-1:0]    lane_valid;
    logic [nl-1:0]    lane_last;
    logic [nl-1:0]    lane_ready;
    logic [sw-1:0]    out_data;
    logic             out_valid;
    logic             out_last;
    logic             out_ready;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [1:0]       wb_adr;
    logic [31:0]      wb_dat_w;
    logic [31:0]      wb_dat_r;
    logic             wb_ack;

    logic [3:0] tb_mask;
    logic [1:0] tb_shift;
    int         obs_samples = 0;
    int         obs_frames = 0;
    int         samples_base;
    int         frames_base;

    // per-lane samples waiting for the other lanes, then whole sets
    iq_combine_pkg::sample_t lane_q      [nl][$];
    logic                    lane_last_q [nl][$];
    iq_combine_pkg::sample_t exp_data    [$];
    logic                    exp_last    [$];

    `include "tb_iq_checks.svh"

    iq_combiner_top #(
        .FIFO_DEPTH(iq_combine_pkg::fifo_depth_default)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .lane_data (lane_data),
        .lane_valid(lane_valid),
        .lane_last (lane_last),
        .lane_ready(lane_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    always #50 clk = ~clk;

    // output checker, sampled mid cycle where the handshake is stable
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            obs_samples = obs_samples + 1;
            if (out_last) begin
                obs_frames = obs_frames + 1;
            end
            if (exp_data.size() == 0) begin
                stray_outputs++;
                $display("output sample at %0t ns arrived with no set pending", $time);
            end else begin
                check_sample(out_data, exp_data.pop_front(), "out_data");
                check_last(out_last, exp_last.pop_front(), "out_last");
            end
        end
    end

    // --------------------------------------------------
    // Wishbone and stream helpers
    // --------------------------------------------------
    task automatic wb_access(input logic we, input logic [1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        cycles = 0;
        @(negedge clk);
        while (!wb_ack && cycles < 16) begin
            @(negedge clk);
            cycles++;
        end
        rdata = wb_dat_r;
        if (!wb_ack) begin
            other_errors++;
            $display("Wishbone access to address %0d got no ack", adr);
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic set_ctrl(input logic [1:0] shift, input logic [3:0] mask);
        logic [31:0] rd;
        wb_access(1'b1, iq_combine_pkg::reg_ctrl, {24'd0, mask, 2'd0, shift}, rd);
        tb_shift = shift;
        tb_mask  = mask;
        wb_access(1'b0, iq_combine_pkg::reg_ctrl, 32'd0, rd);
        check_word(rd, {24'd0, mask, 2'd0, shift}, "ctrl register");
    endtask

    task automatic check_counters();
        logic [31:0] rd;
        wb_access(1'b0, iq_combine_pkg::reg_samples, 32'd0, rd);
        check_word(rd, 32'(obs_samples - samples_base), "sample counter");
        wb_access(1'b0, iq_combine_pkg::reg_frames, 32'd0, rd);
        check_word(rd, 32'(obs_frames - frames_base), "frame counter");
    endtask

    task automatic drive_ready(input logic rand_ready);
        if (rand_ready) begin
            out_ready <= (rand_below(2) == 0);
        end else begin
            out_ready <= 1'b1;
        end
    endtask

    function automatic bit set_complete();
        bit ok;
        ok = (tb_mask != 4'hf);
        for (int l = 0; l < nl; l++) begin
            if (!tb_mask[l] && lane_q[l].size() == 0) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // masked lanes count as zero samples that always end a frame
    task automatic build_sets();
        logic [nl*sw-1:0] set_data;
        logic             set_last;
        while (set_complete()) begin
            set_data = '0;
            set_last = 1'b1;
            for (int l = 0; l < nl; l++) begin
                if (!tb_mask[l]) begin
                    set_data[l*sw +: sw] = lane_q[l].pop_front();
                    set_last = set_last & lane_last_q[l].pop_front();
                end
            end
            exp_data.push_back(ref_combine(set_data, tb_mask, tb_shift));
            exp_last.push_back(set_last);
        end
    endtask

    task automatic send_frames(input int n_frames, input int gap, input logic rand_ready);
        logic                    last_pat [$];
        iq_combine_pkg::sample_t cur      [nl];
        logic                    holding  [nl];
        int                      idx      [nl];
        int                      len;
        int                      cycles;
        bit                      pending;
        // every lane carries the same frame layout
        for (int f = 0; f < n_frames; f++) begin
            len = 1 + rand_below(4);
            for (int w = 0; w < len; w++) begin
                last_pat.push_back(w == len - 1);
            end
        end
        for (int l = 0; l < nl; l++) begin
            idx[l]     = 0;
            holding[l] = 1'b0;
        end
        cycles  = 0;
        pending = (last_pat.size() > 0);
        while (pending && cycles < 4000) begin
            @(posedge clk);
            drive_ready(rand_ready);
            for (int l = 0; l < nl; l++) begin
                if (!holding[l] && idx[l] < last_pat.size() && rand_below(gap + 1) == 0) begin
                    cur[l]     = lcg_next();
                    holding[l] = 1'b1;
                    lane_data[l*sw +: sw] <= cur[l];
                    lane_last[l]          <= last_pat[idx[l]];
                end
                lane_valid[l] <= holding[l];
            end
            @(negedge clk);
            pending = 1'b0;
            for (int l = 0; l < nl; l++) begin
                if (holding[l] && tb_mask[l] && !lane_ready[l]) begin
                    other_errors++;
                    $display("masked lane %0d dropped lane_ready at %0t ns", l, $time);
                end
                if (holding[l] && lane_ready[l]) begin
                    if (!tb_mask[l]) begin
                        lane_q[l].push_back(cur[l]);
                        lane_last_q[l].push_back(last_pat[idx[l]]);
                    end
                    idx[l]++;
                    holding[l] = 1'b0;
                end
                if (idx[l] < last_pat.size()) begin
                    pending = 1'b1;
                end
            end
            build_sets();
            cycles++;
        end
        if (pending) begin
            other_errors++;
            $display("lane inputs were not all accepted within 4000 cycles");
        end
        @(posedge clk);
        lane_valid <= '0;
    endtask

    task automatic wait_drain(input logic rand_ready);
        int cycles;
        cycles = 0;
        while (exp_data.size() != 0 && cycles < 2000) begin
            @(posedge clk);
            drive_ready(rand_ready);
            @(negedge clk);
            cycles++;
        end
        if (exp_data.size() != 0) begin
            other_errors++;
            $display("%0d expected samples never came out", exp_data.size());
        end
        @(posedge clk);
        out_ready <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] rd;
        clk          = 1'b0;
        reset        = 1'b1;
        lane_data    = '0;
        lane_valid   = '0;
        lane_last    = '0;
        out_ready    = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        tb_mask      = '0;
        tb_shift     = '0;
        samples_base = 0;
        frames_base  = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        check_word({31'd0, out_valid}, 32'd0, "out_valid");
        check_word({31'd0, wb_ack}, 32'd0, "wb_ack");
        check_word({28'd0, lane_ready}, 32'h0000000f, "lane_ready");
        wb_access(1'b0, iq_combine_pkg::reg_ctrl, 32'd0, rd);
        check_word(rd, 32'd0, "ctrl register");
        check_counters();

        // unscaled sums on skewed lanes
        set_ctrl(iq_combine_pkg::shift_none, 4'h0);
        send_frames(8, 3, 1'b0);
        wait_drain(1'b0);
        check_counters();

        // shift codes 1, 2 and the unused code 3
        for (int s = 1; s < 4; s++) begin
            set_ctrl(2'(s), 4'h0);
            send_frames(6, 2, 1'b0);
            wait_drain(1'b0);
        end

        set_ctrl(iq_combine_pkg::shift_none, 4'b0101);
        send_frames(6, 2, 1'b0);
        wait_drain(1'b0);
        set_ctrl(iq_combine_pkg::shift_half, 4'b1000);
        send_frames(6, 1, 1'b0);
        wait_drain(1'b0);

        // lanes at full rate against a sink that stalls at random
        set_ctrl(iq_combine_pkg::shift_quarter, 4'h0);
        send_frames(20, 0, 1'b1);
        wait_drain(1'b1);
        check_counters();

        wb_access(1'b1, iq_combine_pkg::reg_samples, 32'd0, rd);
        wb_access(1'b1, iq_combine_pkg::reg_frames, 32'd0, rd);
        samples_base = obs_samples;
        frames_base  = obs_frames;
        check_counters();

        $display("error counts: sample %0d, last %0d, word %0d, other %0d, stray %0d",
                 sample_errors, last_errors, word_errors, other_errors, stray_outputs);
        if (sample_errors + last_errors + word_errors + other_errors + stray_outputs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
